/* common/aesPkg.sv */
/*
 * AES-128 core types: state and word structs, Wishbone bundles,
 * register map and round constants.
 */
package aesPkg;

	// one column of the state, b0 is the top row.
	typedef struct packed {
		logic [7:0] b0;
		logic [7:0] b1;
		logic [7:0] b2;
		logic [7:0] b3;
	} aesWordT;

	// c0 holds FIPS bytes 0..3.
	typedef struct packed {
		aesWordT c0;
		aesWordT c1;
		aesWordT c2;
		aesWordT c3;
	} aesStateT;

	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		logic [3:0]  adr; // word address.
		logic [31:0] dat;
		logic [3:0]  sel;
	} wbReqT;

	typedef struct packed {
		logic        ack;
		logic [31:0] dat;
	} wbRspT;

	typedef logic [3:0] roundCntT;

	localparam int numRounds = 10;

	localparam logic [7:0] rconTable [0:9] = '{
		8'h01, 8'h02, 8'h04, 8'h08, 8'h10,
		8'h20, 8'h40, 8'h80, 8'h1b, 8'h36
	};

	// ========================================
	// register map, word addresses.
	// ========================================
	localparam logic [3:0] regKey0 = 4'd0;
	localparam logic [3:0] regPt0  = 4'd4;
	localparam logic [3:0] regCtrl = 4'd8;
	localparam logic [3:0] regCt0  = 4'd12;

endpackage

/* round/aesSbox.sv */
/*
 * Forward AES S-box, combinational byte lookup.
 */
`timescale 1ns/100ps

module aesSbox (
	input  logic [7:0] inByte,
	output logic [7:0] outByte
);

	// rows of 16 entries, high nibble selects the row.
	localparam logic [7:0] sboxTable [0:255] = '{
		8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
		8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
		8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
		8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
		8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
		8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
		8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
		8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
		8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
		8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
		8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
		8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
		8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
		8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
		8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
		8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
		8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
		8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
		8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
		8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
		8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
		8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
		8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
		8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
		8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
		8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
		8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
		8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
		8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
		8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
		8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
		8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
	};

	assign outByte = sboxTable[inByte];

endmodule

/* round/aesRoundTransform.sv */
/*
 * Round transform: SubBytes, ShiftRows, MixColumns.
 * MixColumns is skipped in the final round.
 */
`timescale 1ns/100ps

module aesRoundTransform (
	input  aesPkg::aesStateT stateIn,
	input  aesPkg::roundCntT round,
	output aesPkg::aesStateT roundData
);
	import aesPkg::*;

	function automatic logic [7:0] xtime(input logic [7:0] b);
		return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
	endfunction

	function automatic aesWordT mixColumn(input aesWordT a);
		aesWordT m;
		m.b0 = xtime(a.b0) ^ xtime(a.b1) ^ a.b1 ^ a.b2 ^ a.b3;
		m.b1 = a.b0 ^ xtime(a.b1) ^ xtime(a.b2) ^ a.b2 ^ a.b3;
		m.b2 = a.b0 ^ a.b1 ^ xtime(a.b2) ^ xtime(a.b3) ^ a.b3;
		m.b3 = xtime(a.b0) ^ a.b0 ^ a.b1 ^ a.b2 ^ xtime(a.b3);
		return m;
	endfunction

	logic [7:0] subB [4][4];   // [column][row].
	logic [7:0] shiftB [4][4];
	aesWordT    outWord [4];
	logic       lastRound;

	// round holds the last finished round, so the final one is numRounds-1.
	assign lastRound = (round == roundCntT'(numRounds - 1));

	for (genvar c = 0; c < 4; c++) begin : gCol
		aesWordT shiftWord;

		for (genvar r = 0; r < 4; r++) begin : gRow
			aesSbox aesSbox_inst (
				.inByte (stateIn[127 - 32*c - 8*r -: 8]),
				.outByte(subB[c][r])
			);
			assign shiftB[c][r] = subB[(c + r) % 4][r]; // row r rotates left by r.
		end

		assign shiftWord = {shiftB[c][0], shiftB[c][1], shiftB[c][2], shiftB[c][3]};
		assign outWord[c] = lastRound ? shiftWord : mixColumn(shiftWord);
	end

	assign roundData = {outWord[0], outWord[1], outWord[2], outWord[3]};

endmodule

/* round/aesKeyExpand.sv */
/*
 * On-the-fly AES-128 key schedule with current round key register.
 */
`timescale 1ns/100ps

module aesKeyExpand (
	input  logic             begintest,
	input  logic             rst,
	input  logic             load,
	input  aesPkg::aesStateT keyIn,
	input  logic             step,
	input  aesPkg::roundCntT round,
	output aesPkg::aesStateT nextKey
);
	import aesPkg::*;

	aesStateT   curKey;
	aesWordT    rotWord;
	aesWordT    subWord;
	aesWordT    temp;
	aesWordT    w0;
	aesWordT    w1;
	aesWordT    w2;
	aesWordT    w3;
	logic [7:0] rcon;

	assign rotWord = {curKey.c3.b1, curKey.c3.b2, curKey.c3.b3, curKey.c3.b0};

	for (genvar i = 0; i < 4; i++) begin : gSub
		aesSbox aesSbox_inst (
			.inByte (rotWord[31 - 8*i -: 8]),
			.outByte(subWord[31 - 8*i -: 8])
		);
	end

	assign rcon = (round < roundCntT'(numRounds)) ? rconTable[round] : 8'h00;
	assign temp = subWord ^ {rcon, 24'h000000};

	// chained xor through the four words.
	assign w0 = curKey.c0 ^ temp;
	assign w1 = curKey.c1 ^ w0;
	assign w2 = curKey.c2 ^ w1;
	assign w3 = curKey.c3 ^ w2;

	assign nextKey = {w0, w1, w2, w3};

	always_ff @(posedge begintest) begin
		if (rst) begin
			curKey <= '0;
		end else if (load) begin
			curKey <= keyIn; // round key 0.
		end else if (step) begin
			curKey <= nextKey;
		end
	end

endmodule

/* round/aesRoundCombine.sv */
/*
 * State register, round counter and AddRoundKey.
 */
`timescale 1ns/100ps

module aesRoundCombine (
	input  logic             begintest,
	input  logic             rst,
	input  logic             startPulse,
	input  aesPkg::aesStateT keyIn,
	input  aesPkg::aesStateT ptIn,
	input  aesPkg::aesStateT nextKey,
	input  aesPkg::aesStateT roundData,
	output aesPkg::aesStateT stateOut,
	output aesPkg::roundCntT round,
	output logic             step,
	output logic             busy,
	output logic             doneStrobe
);
	import aesPkg::*;

	logic lastDone;

	// state holds the ciphertext once round reaches numRounds.
	assign lastDone   = (round == roundCntT'(numRounds));
	assign doneStrobe = busy && lastDone;
	assign step       = busy && !lastDone;

	// ========================================
	// control.
	// ========================================
	always_ff @(posedge begintest) begin
		if (rst) begin
			busy  <= 1'b0;
			round <= '0;
		end else if (startPulse && !busy) begin
			busy  <= 1'b1;
			round <= '0;
		end else if (doneStrobe) begin
			busy <= 1'b0;
		end else if (step) begin
			round <= round + 4'd1;
		end
	end

	// ========================================
	// datapath.
	// ========================================
	always_ff @(posedge begintest) begin
		if (startPulse && !busy) begin
			stateOut <= ptIn ^ keyIn; // initial key addition.
		end else if (step) begin
			stateOut <= roundData ^ nextKey;
		end
	end

endmodule

/* verilog/aesWbSlave.sv */
/*
 * Wishbone classic slave: key, plaintext, control and ciphertext
 * registers, ack generation and sticky done status.
 */
`timescale 1ns/100ps

module aesWbSlave (
	input  logic             begintest,
	input  logic             rst,
	input  aesPkg::wbReqT    wbReq,
	output aesPkg::wbRspT    wbRsp,
	input  logic             busy,
	input  logic             doneStrobe,
	input  aesPkg::aesStateT stateOut,
	output aesPkg::aesStateT keyIn,
	output aesPkg::aesStateT ptIn,
	output logic             startPulse
);
	import aesPkg::*;

	logic        req;
	logic        armed; // cleared by an ack until stb drops.
	logic        accept;
	logic        ackQ;
	logic [31:0] rdatQ;
	logic        doneQ;
	aesStateT    ctReg;
	logic [1:0]  idx;

	assign req    = wbReq.cyc && wbReq.stb;
	assign accept = req && armed;
	assign idx    = wbReq.adr[1:0];

	assign wbRsp.ack = ackQ;
	assign wbRsp.dat = rdatQ;

	always_ff @(posedge begintest) begin
		if (rst) begin
			ackQ       <= 1'b0;
			armed      <= 1'b1;
			startPulse <= 1'b0;
			doneQ      <= 1'b0;
			keyIn      <= '0;
			ptIn       <= '0;
			ctReg      <= '0;
		end else begin
			ackQ       <= accept;
			startPulse <= 1'b0;
			if (accept) armed <= 1'b0;
			else if (!wbReq.stb) armed <= 1'b1;

			// ========================================
			// writes, ignored while busy.
			// ========================================
			if (accept && wbReq.we && !busy) begin
				if (wbReq.adr[3:2] == regKey0[3:2]) keyIn[{~idx, 5'd0} +: 32] <= wbReq.dat;
				if (wbReq.adr[3:2] == regPt0[3:2]) ptIn[{~idx, 5'd0} +: 32] <= wbReq.dat;
				if (wbReq.adr == regCtrl && wbReq.dat[0]) begin
					startPulse <= 1'b1;
					doneQ      <= 1'b0; // new start clears done.
				end
			end

			if (doneStrobe) begin
				ctReg <= stateOut;
				doneQ <= 1'b1;
			end
		end
	end

	// read data, valid during ack.
	always_ff @(posedge begintest) begin
		if (accept) begin
			unique case (wbReq.adr[3:2])
				regKey0[3:2]: rdatQ <= keyIn[{~idx, 5'd0} +: 32];
				regPt0[3:2]:  rdatQ <= ptIn[{~idx, 5'd0} +: 32];
				regCtrl[3:2]: rdatQ <= (wbReq.adr == regCtrl) ? {30'd0, doneQ, busy} : 32'd0;
				default:      rdatQ <= ctReg[{~idx, 5'd0} +: 32];
			endcase
		end
	end

endmodule

/* verilog/aesCoreTop.sv */
/*
 * AES-128 core top: Wishbone slave plus iterative round block.
 */
`timescale 1ns/100ps

module aesCoreTop (
	input  logic          begintest,
	input  logic          rst,
	input  aesPkg::wbReqT wbReq,
	output aesPkg::wbRspT wbRsp
);
	import aesPkg::*;

	aesStateT keyIn;
	aesStateT ptIn;
	aesStateT stateOut;
	aesStateT roundData;
	aesStateT nextKey;
	roundCntT round;
	logic     startPulse;
	logic     step;
	logic     busy;
	logic     doneStrobe;

	aesWbSlave aesWbSlave_inst (
		.begintest (begintest),
		.rst       (rst),
		.wbReq     (wbReq),
		.wbRsp     (wbRsp),
		.busy      (busy),
		.doneStrobe(doneStrobe),
		.stateOut  (stateOut),
		.keyIn     (keyIn),
		.ptIn      (ptIn),
		.startPulse(startPulse)
	);

	aesRoundTransform aesRoundTransform_inst (
		.stateIn  (stateOut),
		.round    (round),
		.roundData(roundData)
	);

	aesKeyExpand aesKeyExpand_inst (
		.begintest(begintest),
		.rst      (rst),
		.load     (startPulse),
		.keyIn    (keyIn),
		.step     (step),
		.round    (round),
		.nextKey  (nextKey)
	);

	aesRoundCombine aesRoundCombine_inst (
		.begintest (begintest),
		.rst       (rst),
		.startPulse(startPulse),
		.keyIn     (keyIn),
		.ptIn      (ptIn),
		.nextKey   (nextKey),
		.roundData (roundData),
		.stateOut  (stateOut),
		.round     (round),
		.step      (step),
		.busy      (busy),
		.doneStrobe(doneStrobe)
	);

endmodule

/* bench/aesCore_checker.sv */
/*
 * Wishbone ack and busy length assertions, bound to the slave.
 */
`timescale 1ns/100ps

module aesCore_checker (
	input logic          begintest,
	input logic          rst,
	input aesPkg::wbReqT wbReq,
	input aesPkg::wbRspT wbRsp,
	input logic          busy
);
	import aesPkg::*;

	int busyRun;         // consecutive busy cycles.
	int assertFails = 0;

	always_ff @(posedge begintest) begin
		if (rst || !busy) begin
			busyRun <= 0;
		end else begin
			busyRun <= busyRun + 1;
		end
	end

	ackAfterReq: assert property (@(posedge begintest) disable iff (rst)
		wbRsp.ack |-> $past(wbReq.cyc && wbReq.stb))
		else begin
			assertFails++;
			$error("ack without a request in the previous cycle");
		end

	singleAck: assert property (@(posedge begintest) disable iff (rst)
		wbRsp.ack |=> !wbRsp.ack)
		else begin
			assertFails++;
			$error("ack held high for two cycles");
		end

	// key addition plus numRounds rounds.
	busyBounded: assert property (@(posedge begintest) disable iff (rst)
		busyRun <= numRounds + 1)
		else begin
			assertFails++;
			$error("busy stayed high longer than %0d cycles", numRounds + 1);
		end

endmodule

bind aesWbSlave aesCore_checker aesCore_checker_inst (
	.begintest(begintest),
	.rst      (rst),
	.wbReq    (wbReq),
	.wbRsp    (wbRsp),
	.busy     (busy)
);

/* bench/aesCoreTb.sv */
/*
 * AES-128 core testbench: Wishbone bus tasks, vector replay from the
 * data file, LFSR idle gaps, watchdog and error summary.
 */
`timescale 1ns/100ps

module aesCoreTb;
	import aesPkg::*;

	logic         begintest;
	logic         rst;
	wbReqT        wbReq;
	wbRspT        wbRsp;
	logic [127:0] vecMem [0:48]; // count, then key/pt/ct triples.
	int           vecCount;
	int           watchdogCycles;
	int           checkCount;
	int           mismatchCount;
	int           otherErrors;
	logic [31:0]  lfsrState;
	logic         gapsOn;

	aesCoreTop aesCoreTop_inst (
		.begintest(begintest),
		.rst      (rst),
		.wbReq    (wbReq),
		.wbRsp    (wbRsp)
	);

	always #2 begintest = ~begintest;

	initial begin
		wait (watchdogCycles > 0);
		repeat (watchdogCycles) @(posedge begintest);
		$display("ERROR: watchdog expired after %0d cycles, the run did not finish",
			watchdogCycles);
		$display("Test failures found");
		$finish;
	end

	// ========================================
	// stimulus helpers.
	// ========================================
	function automatic logic [31:0] nextLfsr(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic drawBits(input int n, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			val       = {val[30:0], lfsrState[0]};
			lfsrState = nextLfsr(lfsrState); // one step per bit.
		end
	endtask

	task automatic idleGap();
		logic [31:0] gap;
		if (gapsOn) begin
			drawBits(2, gap);
			repeat (gap) @(posedge begintest);
		end
	endtask

	task automatic checkValue(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checkCount++;
		if (actual !== expected) begin
			mismatchCount++;
			$display("CHECK FAILED %s: expected %08h, actual %08h", name, expected, actual);
		end
	endtask

	// one classic cycle, held until ack, then stb drops for a cycle.
	task automatic busAccess(input logic we, input logic [3:0] adr, input logic [31:0] wdata,
			output logic [31:0] rdata);
		int waitCycles;
		idleGap();
		@(posedge begintest);
		#0.5;
		wbReq = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdata, sel: 4'hf};
		waitCycles = 0;
		rdata = '0;
		do begin
			@(negedge begintest);
			waitCycles++;
		end while (!wbRsp.ack && waitCycles < 16);
		if (wbRsp.ack) begin
			rdata = wbRsp.dat;
		end else begin
			otherErrors++;
			$display("ERROR: no ack for the access to word address %0d", adr);
		end
		@(posedge begintest);
		#0.5;
		wbReq = '0;
	endtask

	task automatic writeReg(input logic [3:0] adr, input logic [31:0] data);
		logic [31:0] unused;
		busAccess(1'b1, adr, data, unused);
	endtask

	task automatic readReg(input logic [3:0] adr, output logic [31:0] data);
		busAccess(1'b0, adr, 32'h0, data);
	endtask

	task automatic loadVector(input logic [127:0] key, input logic [127:0] pt);
		for (int i = 0; i < 4; i++) begin
			writeReg(regKey0 + 4'(i), key[127 - 32*i -: 32]);
		end
		for (int i = 0; i < 4; i++) begin
			writeReg(regPt0 + 4'(i), pt[127 - 32*i -: 32]);
		end
	endtask

	task automatic pollDone(input string name, input logic expectBusy);
		logic [31:0] status;
		int          polls;
		readReg(regCtrl, status);
		if (expectBusy) begin
			checkValue({name, " status after start"}, 32'h1, status);
		end
		polls = 0;
		while (status != 32'h2 && polls < 40) begin
			readReg(regCtrl, status);
			polls++;
		end
		if (polls >= 40) begin
			otherErrors++;
			$display("ERROR: %s never reported done", name);
		end
		checkValue({name, " status when done"}, 32'h2, status);
	endtask

	task automatic checkCipher(input string name, input logic [127:0] expected);
		logic [31:0] word;
		for (int i = 0; i < 4; i++) begin
			readReg(regCt0 + 4'(i), word);
			checkValue({name, " ciphertext"}, expected[127 - 32*i -: 32], word);
		end
	endtask

	// ========================================
	// tests.
	// ========================================
	task automatic checkReset();
		logic [31:0] word;
		readReg(regCtrl, word);
		checkValue("reset status", 32'h0, word);
		checkCipher("reset", 128'h0);
	endtask

	task automatic runVector(input int idx, input logic readBack);
		logic [127:0] key;
		logic [127:0] pt;
		logic [31:0]  word;
		string        name;
		key  = vecMem[1 + 3*idx];
		pt   = vecMem[2 + 3*idx];
		name = $sformatf("vector %0d", idx);
		loadVector(key, pt);
		if (readBack) begin
			for (int i = 0; i < 4; i++) begin
				readReg(regKey0 + 4'(i), word);
				checkValue({name, " key readback"}, key[127 - 32*i -: 32], word);
				readReg(regPt0 + 4'(i), word);
				checkValue({name, " plaintext readback"}, pt[127 - 32*i -: 32], word);
			end
		end
		writeReg(regCtrl, 32'h1);
		pollDone(name, 1'b1);
		checkCipher(name, vecMem[3 + 3*idx]);
	endtask

	task automatic runBusyWrites(input int idx);
		logic [127:0] key;
		logic [127:0] pt;
		logic [31:0]  word;
		key = vecMem[1 + 3*idx];
		pt  = vecMem[2 + 3*idx];
		loadVector(key, pt);
		writeReg(regCtrl, 32'h1);
		// these three land inside the 11 busy cycles.
		writeReg(regKey0, ~key[127:96]);
		writeReg(regPt0, ~pt[127:96]);
		writeReg(regCtrl, 32'h1);
		pollDone("busy writes", 1'b0);
		checkCipher("busy writes", vecMem[3 + 3*idx]);
		readReg(regKey0, word);
		checkValue("busy writes key kept", key[127:96], word);
		readReg(regPt0, word);
		checkValue("busy writes plaintext kept", pt[127:96], word);
	endtask

	initial begin
		int maxVecs;
		int assertFails;
		begintest      = 1'b0;
		rst            = 1'b1;
		wbReq          = '0;
		lfsrState      = 32'h7f27f41b;
		gapsOn         = 1'b0;
		checkCount     = 0;
		mismatchCount  = 0;
		otherErrors    = 0;
		watchdogCycles = 0;
		$readmemh("bench/aesTestdata.hex", vecMem);
		maxVecs        = ($size(vecMem) - 1) / 3;
		vecCount       = int'(vecMem[0][15:0]);
		watchdogCycles = vecCount * 200 + 500;

		repeat (2) @(posedge begintest);
		#0.5;
		rst = 1'b0;

		checkReset();
		if (vecCount < 1 || vecCount > maxVecs) begin
			otherErrors++;
			$display("ERROR: test data file holds no usable vector count (%0d)", vecCount);
		end else begin
			for (int i = 0; i < vecCount; i++) begin
				runVector(i, 1'b1);
			end
			runBusyWrites(0);
			gapsOn = 1'b1; // back to back with random idle cycles.
			for (int i = 0; i < vecCount; i++) begin
				runVector(i, 1'b0);
			end
		end

		assertFails = aesCoreTop_inst.aesWbSlave_inst.aesCore_checker_inst.assertFails;
		$display("Summary: %0d checks, %0d mismatches, %0d other errors, %0d assertion failures",
			checkCount, mismatchCount, otherErrors, assertFails);
		if (mismatchCount == 0 && otherErrors == 0 && assertFails == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

/* bench/aesTestdata.hex */
// vector count, then one vector per line: key, plaintext, expected ciphertext.
// each value is a 128-bit word in FIPS-197 byte order, byte 0 leftmost.
07
// FIPS-197 appendix B
2b7e151628aed2a6abf7158809cf4f3c 3243f6a8885a308d313198a2e0370734 3925841d02dc09fbdc118597196a0b32
// FIPS-197 appendix C.1
000102030405060708090a0b0c0d0e0f 00112233445566778899aabbccddeeff 69c4e0d86a7b0430d8cdb78070b4c55a
// all-zero key and plaintext
00000000000000000000000000000000 00000000000000000000000000000000 66e94bd4ef8a2c3b884cfa59ca342b2e
// SP 800-38A ECB blocks 1 to 4
2b7e151628aed2a6abf7158809cf4f3c 6bc1bee22e409f96e93d7e117393172a 3ad77bb40d7a3660a89ecaf32466ef97
2b7e151628aed2a6abf7158809cf4f3c ae2d8a571e03ac9c9eb76fac45af8e51 f5d3d58503b9699de785895a96fdbaaf
2b7e151628aed2a6abf7158809cf4f3c 30c81c46a35ce411e5fbc1191a0a52ef 43b1cd7f598ece23881b00e3ed030688
2b7e151628aed2a6abf7158809cf4f3c f69f2445df4f9b17ad2b417be66c3710 7b0c785e27e8ad3f8223207104725dd4

/* files.f */
common/aesPkg.sv
round/aesSbox.sv
round/aesRoundTransform.sv
round/aesKeyExpand.sv
round/aesRoundCombine.sv
verilog/aesWbSlave.sv
verilog/aesCoreTop.sv
bench/aesCore_checker.sv
bench/aesCoreTb.sv

/* Makefile */
# Verilator build and run of the AES-128 core testbench.

VERILATOR ?= verilator
TOP       ?= aesCoreTb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100
FAIL_MSG  := Test failures found

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@status=0; $(SIM_BIN) $(SIM_ARGS) > $(LOG) 2>&1 || status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
